// File: compile.f
src/apb_pkg.sv
src/periph_map_pkg.sv
src/apb_addr_decoder.sv
src/periph_reg_slot.sv
src/apb_resp_mux.sv
src/periph_bus_top.sv
sim/periph_bus_properties.sv
sim/periph_bus_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the APB peripheral testbench with Verilator and runs it.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --assert -Wno-fatal \
	--top-module periph_bus_tb \
	-f compile.f \
	-o periph_bus_sim

# Keep running past assertion errors so the testbench can report them.
./obj_dir/periph_bus_sim +verilator+error+limit+1000 2>&1 | tee "$LOG"

if grep -q "SIMULATION FAILED" "$LOG"; then
	echo "Run failed, see $LOG"
	exit 1
fi

echo "Run finished without failures"
exit 0

// File: sim/periph_bus_properties.sv
module periph_bus_properties #(
	parameter int NB_SLOT     = 4,
	parameter int WAIT_STATES = 1
) (
	input logic              clk_i,
	input logic              reset,
	input apb_pkg::apb_req_t req,
	input apb_pkg::apb_rsp_t rsp
);
	import apb_pkg::*;
	import periph_map_pkg::*;

	int unsigned               fail_count = 0;
	logic [APB_DATA_WIDTH-1:0] shadow [NB_SLOT][ID_REG];
	logic [APB_ADDR_WIDTH-1:0] offset;
	logic [APB_ADDR_WIDTH-1:0] win;
	logic                      mapped;
	logic                      in_reg;
	logic [1:0]                word;
	logic                      access;
	logic                      done;
	int unsigned               waited;

	assign offset = req.paddr - MAP_BASE;
	assign win    = offset >> REGION_SHIFT; // Window index.
	assign mapped = (req.paddr >= MAP_BASE) && (win < APB_ADDR_WIDTH'(NB_SLOT));
	assign in_reg = (req.paddr[REGION_SHIFT-1:0] < REGION_SHIFT'(REG_SPAN));
	assign word   = req.paddr[3:2];
	assign access = req.psel & req.penable;
	assign done   = access & rsp.pready;

	always_ff @(posedge clk_i) begin
		if (reset) begin
			for (int i = 0; i < NB_SLOT; i++) begin
				for (int j = 0; j < ID_REG; j++) begin
					shadow[i][j] <= '0;
				end
			end
		end else if (done && req.pwrite && !rsp.pslverr && mapped && in_reg &&
				word != 2'(ID_REG)) begin
			shadow[win][word] <= req.pwdata;
		end
	end

	// Access cycles seen before pready.
	always_ff @(posedge clk_i) begin
		if (reset) begin
			waited <= 0;
		end else if (!access || rsp.pready) begin
			waited <= 0;
		end else begin
			waited <= waited + 1;
		end
	end

	readback: assert property (@(posedge clk_i) disable iff (reset)
		(done && !req.pwrite && mapped && in_reg && word != 2'(ID_REG)) |->
		(rsp.prdata == shadow[win][word] && !rsp.pslverr))
		else begin
			$error("read data differs from the last write to that register");
			fail_count++;
		end

	identity: assert property (@(posedge clk_i) disable iff (reset)
		(done && !req.pwrite && mapped && in_reg && word == 2'(ID_REG)) |->
		(rsp.prdata == win && !rsp.pslverr))
		else begin
			$error("identity register does not return the slot index");
			fail_count++;
		end

	miss_rsp: assert property (@(posedge clk_i) disable iff (reset)
		(req.psel && !req.penable && !mapped) |=>
		(req.penable && rsp.pready && rsp.pslverr && rsp.prdata == '0))
		else begin
			$error("unmapped address not answered with an error in the first access cycle");
			fail_count++;
		end

	slot_err: assert property (@(posedge clk_i) disable iff (reset)
		(done && mapped && (!in_reg || (req.pwrite && word == 2'(ID_REG)))) |-> rsp.pslverr)
		else begin
			$error("bad offset or identity write completed without pslverr");
			fail_count++;
		end

	wait_states: assert property (@(posedge clk_i) disable iff (reset)
		(done && mapped) |-> (waited == WAIT_STATES))
		else begin
			$error("pready did not rise after the configured wait states");
			fail_count++;
		end

	reset_quiet: assert property (@(posedge clk_i)
		(reset || $past(reset)) |-> !rsp.pready)
		else begin
			$error("pready high during or right after reset");
			fail_count++;
		end

endmodule

bind periph_bus_top periph_bus_properties #(
	.NB_SLOT    (NB_SLOT),
	.WAIT_STATES(WAIT_STATES)
) props_inst (
	.clk_i(clk_i),
	.reset(reset),
	.req  (req),
	.rsp  (rsp)
);

// File: sim/periph_bus_tb.sv
module periph_bus_tb;
	import apb_pkg::*;
	import periph_map_pkg::*;

	localparam int NB_SLOT     = 4;
	localparam int WAIT_STATES = 1;
	localparam int TIMEOUT     = 20; // Cycles allowed for pready.

	logic     clk_i = 1'b0;
	logic     reset = 1'b1;
	apb_req_t req   = '0;
	apb_rsp_t rsp;

	logic [31:0] lfsr = 32'h6b93f738;
	logic [31:0] model [NB_SLOT][ID_REG]; // Expected register contents.
	int          timeouts   = 0;
	int          mismatches = 0;

	periph_bus_top #(
		.NB_SLOT    (NB_SLOT),
		.WAIT_STATES(WAIT_STATES)
	) periph_bus_top_inst (
		.clk_i(clk_i),
		.reset(reset),
		.req  (req),
		.rsp  (rsp)
	);

	always #4 clk_i = ~clk_i;

	// Fibonacci LFSR with taps 32 22 2 1.
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] val;
		logic        fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			val  = {val[30:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] reg_addr(input int slot, input int r);
		return MAP_BASE + (32'(slot) << REGION_SHIFT) + 32'(r * 4);
	endfunction

	// Setup cycle, then access cycles until pready.
	task automatic run_transfer(input logic [31:0] addr, input logic write,
			input logic [31:0] wdata, input logic [31:0] exp_data, input logic exp_err);
		int cycles;
		cycles      = 0;
		req.paddr   = addr;
		req.pwdata  = wdata;
		req.pwrite  = write;
		req.psel    = 1'b1;
		req.penable = 1'b0;
		@(posedge clk_i);
		#1;
		req.penable = 1'b1;
		do begin
			@(negedge clk_i); // Response is settled mid-cycle.
			cycles++;
		end while (!rsp.pready && cycles < TIMEOUT);
		if (!rsp.pready) begin
			$display("Timeout at %0t: the completer never answered the transfer to %h",
				$time, addr);
			timeouts++;
		end else if (rsp.pslverr !== exp_err ||
				(!write && !exp_err && rsp.prdata !== exp_data)) begin
			$display("Error at %0t: %s of %h gave data %h err %b, expected data %h err %b",
				$time, write ? "write" : "read", addr, rsp.prdata, rsp.pslverr,
				exp_data, exp_err);
			mismatches++;
		end
		@(posedge clk_i);
		#1;
		req.psel    = 1'b0;
		req.penable = 1'b0;
		req.pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
			input logic exp_err);
		run_transfer(addr, 1'b1, data, '0, exp_err);
	endtask

	task automatic apb_read(input logic [31:0] addr, input logic [31:0] exp_data,
			input logic exp_err);
		run_transfer(addr, 1'b0, '0, exp_data, exp_err);
	endtask

	task automatic write_reg(input int slot, input int r, input logic [31:0] data);
		logic bad;
		bad = (r == ID_REG); // Identity register is read only.
		apb_write(reg_addr(slot, r), data, bad);
		if (!bad) begin
			model[slot][r] = data;
		end
	endtask

	task automatic read_reg(input int slot, input int r);
		if (r == ID_REG) begin
			apb_read(reg_addr(slot, r), 32'(slot), 1'b0);
		end else begin
			apb_read(reg_addr(slot, r), model[slot][r], 1'b0);
		end
	endtask

	initial begin
		int          slot;
		int          r;
		logic [31:0] data;
		int          errors;
		for (int s = 0; s < NB_SLOT; s++) begin
			for (int i = 0; i < ID_REG; i++) begin
				model[s][i] = '0;
			end
		end

		// An access phase held through reset must get no answer and store nothing.
		req.paddr   = reg_addr(1, 0);
		req.pwdata  = 32'hffff_ffff;
		req.pwrite  = 1'b1;
		req.psel    = 1'b1;
		req.penable = 1'b1;
		repeat (5) @(posedge clk_i);
		#1;
		reset = 1'b0;
		@(posedge clk_i);
		#1;
		req = '0;

		// Reset values and identity of every slot.
		for (int s = 0; s < NB_SLOT; s++) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				read_reg(s, i);
			end
		end

		repeat (48) begin
			slot = int'(rand_bits(2));
			r    = int'(rand_bits(2));
			data = rand_bits(32);
			write_reg(slot, r, data);
			read_reg(int'(rand_bits(2)), int'(rand_bits(2)));
		end

		// Unmapped addresses below the base and past the last window.
		apb_read(MAP_BASE - 32'h4, '0, 1'b1);
		apb_read(reg_addr(NB_SLOT, 0), '0, 1'b1);
		apb_write(32'h0000_0100, rand_bits(32), 1'b1);
		apb_write(MAP_BASE + 32'h0010_0000, rand_bits(32), 1'b1);

		// Offsets beyond the register block.
		apb_write(reg_addr(2, 0) + 32'h10, rand_bits(32), 1'b1);
		apb_write(reg_addr(0, 0) + 32'hffc, rand_bits(32), 1'b1);
		apb_read(reg_addr(1, 0) + 32'h40, '0, 1'b1);
		write_reg(3, ID_REG, rand_bits(32));

		for (int s = 0; s < NB_SLOT; s++) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				read_reg(s, i);
			end
		end

		errors = timeouts + mismatches + periph_bus_top_inst.props_inst.fail_count;
		$display("Timeouts %0d, mismatches %0d, assertion failures %0d", timeouts, mismatches,
			periph_bus_top_inst.props_inst.fail_count);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

// File: src/apb_addr_decoder.sv
module apb_addr_decoder #(
	parameter int NB_SLOT = 4
) (
	input  logic               clk_i,
	input  logic               reset,
	input  apb_pkg::apb_req_t  req,
	output logic [NB_SLOT-1:0] slot_sel,
	output logic               miss
);
	import apb_pkg::*;
	import periph_map_pkg::*;

	logic                      setup;
	logic [APB_ADDR_WIDTH-1:0] offset;
	logic                      above_base;
	logic [SLOT_IDX_W-1:0]     win_idx;
	logic                      high_zero;
	logic                      idx_ok;
	logic                      hit;
	logic [NB_SLOT-1:0]        sel_next;

	if (NB_SLOT < 1 || NB_SLOT > MAX_SLOTS) begin : g_bad_cfg
		$error("apb_addr_decoder: NB_SLOT must be between 1 and MAX_SLOTS");
	end

	assign setup = req.psel & ~req.penable;

	// Window index relative to the map base.
	assign offset     = req.paddr - MAP_BASE;
	assign above_base = (req.paddr >= MAP_BASE);
	assign win_idx    = offset[REGION_SHIFT +: SLOT_IDX_W];
	assign high_zero  = (offset[APB_ADDR_WIDTH-1:REGION_SHIFT+SLOT_IDX_W] == '0);
	assign idx_ok     = ({1'b0, win_idx} < (SLOT_IDX_W + 1)'(NB_SLOT));
	assign hit        = above_base & high_zero & idx_ok;

	always_comb begin
		sel_next = '0;
		for (int i = 0; i < NB_SLOT; i++) begin
			if (hit && win_idx == SLOT_IDX_W'(i)) begin
				sel_next[i] = 1'b1;
			end
		end
	end

	// Captured in the setup cycle, held through the access phase.
	always_ff @(posedge clk_i) begin
		if (reset) begin
			slot_sel <= '0;
			miss     <= 1'b0;
		end else if (!req.psel) begin
			slot_sel <= '0;
			miss     <= 1'b0;
		end else if (setup) begin
			slot_sel <= sel_next;
			miss     <= ~hit;
		end
	end

endmodule

// File: src/apb_pkg.sv
package apb_pkg;

	localparam int APB_ADDR_WIDTH = 32;
	localparam int APB_DATA_WIDTH = 32;

	// Initiator side of the bus.
	typedef struct packed {
		logic [APB_ADDR_WIDTH-1:0] paddr;
		logic [APB_DATA_WIDTH-1:0] pwdata;
		logic                      pwrite;
		logic                      psel;
		logic                      penable;
	} apb_req_t;

	// Completer side of the bus.
	typedef struct packed {
		logic [APB_DATA_WIDTH-1:0] prdata;
		logic                      pready;
		logic                      pslverr;
	} apb_rsp_t;

endpackage

// File: src/apb_resp_mux.sv
module apb_resp_mux #(
	parameter int NB_SLOT = 4
) (
	input  apb_pkg::apb_req_t  req,
	input  logic [NB_SLOT-1:0] slot_sel,
	input  logic               miss,
	input  apb_pkg::apb_rsp_t  slot_rsp [NB_SLOT],
	output apb_pkg::apb_rsp_t  rsp
);
	import apb_pkg::*;

	logic                      miss_access;
	logic [APB_DATA_WIDTH-1:0] or_rdata;
	logic                      or_ready;
	logic                      or_err;

	assign miss_access = miss & req.psel & req.penable;

	// At most one slot is selected, so an OR is enough.
	always_comb begin
		or_rdata = '0;
		or_ready = 1'b0;
		or_err   = 1'b0;
		for (int i = 0; i < NB_SLOT; i++) begin
			if (slot_sel[i]) begin
				or_rdata = or_rdata | slot_rsp[i].prdata;
				or_ready = or_ready | slot_rsp[i].pready;
				or_err   = or_err | slot_rsp[i].pslverr;
			end
		end
	end

	always_comb begin
		if (miss_access) begin
			rsp.prdata  = '0; // Unmapped address.
			rsp.pready  = 1'b1;
			rsp.pslverr = 1'b1;
		end else begin
			rsp.prdata  = or_rdata;
			rsp.pready  = or_ready;
			rsp.pslverr = or_err;
		end
	end

endmodule

// File: src/periph_bus_top.sv
module periph_bus_top #(
	parameter int NB_SLOT     = 4,
	parameter int WAIT_STATES = 1
) (
	input  logic              clk_i,
	input  logic              reset,
	input  apb_pkg::apb_req_t req,
	output apb_pkg::apb_rsp_t rsp
);
	import apb_pkg::*;

	logic [NB_SLOT-1:0] slot_sel;
	logic               miss;
	apb_rsp_t           slot_rsp [NB_SLOT];

	apb_addr_decoder #(
		.NB_SLOT(NB_SLOT)
	) apb_addr_decoder_inst (
		.clk_i   (clk_i),
		.reset   (reset),
		.req     (req),
		.slot_sel(slot_sel),
		.miss    (miss)
	);

	// One register peripheral per 4 KiB window.
	for (genvar i = 0; i < NB_SLOT; i++) begin : g_slot
		periph_reg_slot #(
			.SLOT_ID    (i),
			.WAIT_STATES(WAIT_STATES)
		) periph_reg_slot_inst (
			.clk_i(clk_i),
			.reset(reset),
			.req  (req),
			.sel  (slot_sel[i]),
			.rsp  (slot_rsp[i])
		);
	end

	apb_resp_mux #(
		.NB_SLOT(NB_SLOT)
	) apb_resp_mux_inst (
		.req     (req),
		.slot_sel(slot_sel),
		.miss    (miss),
		.slot_rsp(slot_rsp),
		.rsp     (rsp)
	);

endmodule

// File: src/periph_map_pkg.sv
package periph_map_pkg;

	// Slot 0 starts here, the others follow one window apart.
	localparam logic [31:0] MAP_BASE = 32'h1a10_0000;
	localparam int REGION_SHIFT = 12; // 4 KiB windows.

	localparam int MAX_SLOTS = 16;
	localparam int SLOT_IDX_W = $clog2(MAX_SLOTS);

	// Register layout inside one window.
	localparam int REG_COUNT = 4;
	localparam int ID_REG = 3; // Read only.
	localparam int REG_IDX_W = $clog2(REG_COUNT);
	localparam int REG_SPAN = REG_COUNT * 4; // Decoded bytes per window.

endpackage

// File: src/periph_reg_slot.sv
module periph_reg_slot #(
	parameter int SLOT_ID     = 0,
	parameter int WAIT_STATES = 1
) (
	input  logic              clk_i,
	input  logic              reset,
	input  apb_pkg::apb_req_t req,
	input  logic              sel,
	output apb_pkg::apb_rsp_t rsp
);
	import apb_pkg::*;
	import periph_map_pkg::*;

	localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

	logic [APB_DATA_WIDTH-1:0] regs [ID_REG];
	logic [CNT_W-1:0]          wait_cnt;
	logic [REG_IDX_W-1:0]      reg_idx;
	logic                      access;
	logic                      ready;
	logic                      out_of_range;
	logic                      id_write;
	logic                      err;
	logic                      do_write;
	logic [APB_DATA_WIDTH-1:0] rdata;

	assign access = sel & req.psel & req.penable;
	assign ready  = access & (wait_cnt == CNT_W'(WAIT_STATES));

	assign reg_idx = req.paddr[2 +: REG_IDX_W]; // Word index.

	// Error cases never touch state.
	assign out_of_range = (req.paddr[REGION_SHIFT-1:0] >= REGION_SHIFT'(REG_SPAN));
	assign id_write     = req.pwrite & (reg_idx == REG_IDX_W'(ID_REG));
	assign err          = out_of_range | id_write;
	assign do_write     = ready & req.pwrite & ~err;

	// Counts access cycles until the transfer completes.
	always_ff @(posedge clk_i) begin
		if (reset) begin
			wait_cnt <= '0;
		end else if (!access || ready) begin
			wait_cnt <= '0;
		end else begin
			wait_cnt <= wait_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reset) begin
			for (int i = 0; i < ID_REG; i++) begin
				regs[i] <= '0;
			end
		end else if (do_write) begin
			for (int i = 0; i < ID_REG; i++) begin
				if (reg_idx == REG_IDX_W'(i)) begin
					regs[i] <= req.pwdata;
				end
			end
		end
	end

	always_comb begin
		rdata = '0;
		if (reg_idx == REG_IDX_W'(ID_REG)) begin
			rdata = APB_DATA_WIDTH'(SLOT_ID); // Identity.
		end else begin
			for (int i = 0; i < ID_REG; i++) begin
				if (reg_idx == REG_IDX_W'(i)) begin
					rdata = regs[i];
				end
			end
		end
	end

	// Quiet unless selected and done waiting.
	assign rsp.pready  = ready;
	assign rsp.pslverr = ready & err;
	assign rsp.prdata  = (ready && !req.pwrite && !err) ? rdata : '0;

endmodule
